//--- common/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	typedef logic [31:0] virt_t;
	typedef logic [4:0]  reg_addr_t;

	// one fetched word seen as R, I or J format
	typedef union packed {
		struct packed {
			logic [5:0] opcode;
			reg_addr_t  rs;
			reg_addr_t  rt;
			reg_addr_t  rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r;
		struct packed {
			logic [5:0]  opcode;
			reg_addr_t   rs;
			reg_addr_t   rt;
			logic [15:0] imm16;
		} i;
		struct packed {
			logic [5:0]  opcode;
			logic [25:0] target26;
		} j;
	} instr_u;

	typedef enum logic [6:0] {
		// shifts
		OP_SLL, OP_SRL, OP_SRA,
		OP_SLLV, OP_SRLV, OP_SRAV,
		// register jump, conditional move, system
		OP_JALR,
		OP_MOVN, OP_MOVZ,
		OP_SYSCALL, OP_BREAK,
		// hi/lo
		OP_MFHI, OP_MTHI, OP_MFLO, OP_MTLO,
		OP_MULT, OP_MULTU, OP_DIV, OP_DIVU,
		// arithmetic and logic
		OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
		OP_AND, OP_OR, OP_XOR, OP_NOR,
		OP_SLT, OP_SLTU,
		// traps
		OP_TGE, OP_TGEU, OP_TLT, OP_TLTU,
		OP_TEQ, OP_TNE,
		// special2
		OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU,
		OP_MUL, OP_CLZ, OP_CLO,
		// branches
		OP_BLTZ, OP_BGEZ, OP_BLTZAL, OP_BGEZAL,
		OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ,
		OP_LUI,
		// memory
		OP_LB, OP_LH, OP_LWL, OP_LW,
		OP_LBU, OP_LHU, OP_LWR,
		OP_SB, OP_SH, OP_SWL, OP_SW, OP_SWR,
		OP_CACHE,
		OP_LL, OP_SC,
		OP_JAL,
		// cop0
		OP_MFC0, OP_MTC0,
		OP_TLBR, OP_TLBWI, OP_TLBWR, OP_TLBP,
		OP_ERET,
		OP_INVALID
	} op_t;

	typedef enum logic [2:0] {
		CF_NONE,
		CF_BRANCH,
		CF_RETURN,
		CF_CALL,
		CF_JUMP
	} cf_t;

	typedef struct packed {
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
		op_t       op;
		logic      use_imm;
		logic      imm_signed;
		logic      is_load;
		logic      is_store;
		logic      is_priv;
		logic      is_nonrw_priv;  // tlb ops and eret
		logic      delayed_exec;
		logic      is_controlflow;
		cf_t       cf;
		virt_t     default_jump_i;  // branch target
		virt_t     default_jump_j;  // j/jal target
	} decoded_instr_t;

endpackage

`default_nettype wire

//--- common/decode_if.sv
`default_nettype none

interface decode_if;

	logic                    valid;
	cpu_pkg::decoded_instr_t rec;
	logic                    ready;

	modport source (
		output valid,
		output rec,
		input  ready
	);

	modport sink (
		input  valid,
		input  rec,
		output ready
	);

endinterface

`default_nettype wire

//--- decoder/decode_branch.sv
`default_nettype none

module decode_branch (
	input  cpu_pkg::instr_u instr,
	output logic            is_branch,
	output logic            is_jump_i,
	output logic            is_jump_r,
	output logic            is_call,
	output logic            is_return
);

	logic [5:0] opcode;
	logic [5:0] funct;
	logic       special;
	logic       regimm_branch;
	logic       regimm_link;

	assign opcode  = instr.r.opcode;
	assign funct   = instr.r.funct;
	assign special = opcode == 6'b000000;

	// bltz, bgez, bltzal, bgezal
	assign regimm_branch = opcode == 6'b000001 && instr.i.rt[3:1] == 3'b000;
	assign regimm_link   = regimm_branch && instr.i.rt[4];

	assign is_branch = opcode[5:2] == 4'b0001 || regimm_branch;
	assign is_jump_i = opcode[5:1] == 5'b00001;
	assign is_jump_r = special && funct[5:1] == 5'b00100;

	assign is_call = opcode == 6'b000011
		|| (special && funct == 6'b001001 && instr.r.rd == 5'd31)
		|| regimm_link;

	assign is_return = special && funct == 6'b001000 && instr.r.rs == 5'd31;  // jr $ra

endmodule

`default_nettype wire

//--- decoder/decoder.sv
`default_nettype none

module decoder #(
	parameter bit delayed_branch = 1'b1
) (
	input  cpu_pkg::virt_t  pc,
	input  cpu_pkg::instr_u instr,
	input  logic            in_valid,
	decode_if.source        dec
);

	logic [5:0]         opcode;
	logic [5:0]         funct;
	cpu_pkg::reg_addr_t rs;
	cpu_pkg::reg_addr_t rt;
	cpu_pkg::reg_addr_t rd;

	cpu_pkg::virt_t pc_plus4;
	cpu_pkg::virt_t jump_i;
	cpu_pkg::virt_t jump_j;

	logic is_branch;
	logic is_jump_i;
	logic is_jump_r;
	logic is_call;
	logic is_return;

	cpu_pkg::cf_t            cf;
	cpu_pkg::decoded_instr_t rec;

	assign opcode = instr.r.opcode;
	assign funct  = instr.r.funct;
	assign rs     = instr.r.rs;
	assign rt     = instr.r.rt;
	assign rd     = instr.r.rd;

	assign pc_plus4 = pc + 32'd4;
	assign jump_i   = pc_plus4 + {{14{instr.i.imm16[15]}}, instr.i.imm16, 2'b00};
	assign jump_j   = {pc_plus4[31:28], instr.j.target26, 2'b00};

	decode_branch u_branch (
		.instr     (instr),
		.is_branch (is_branch),
		.is_jump_i (is_jump_i),
		.is_jump_r (is_jump_r),
		.is_call   (is_call),
		.is_return (is_return)
	);

	always_comb begin
		if (is_branch)
			cf = cpu_pkg::CF_BRANCH;
		else if (is_return)
			cf = cpu_pkg::CF_RETURN;
		else if (is_call)
			cf = cpu_pkg::CF_CALL;
		else if (is_jump_i || is_jump_r)
			cf = cpu_pkg::CF_JUMP;
		else
			cf = cpu_pkg::CF_NONE;
	end

	always_comb begin
		rec                = '0;
		rec.op             = cpu_pkg::OP_SLL;
		rec.imm_signed     = 1'b1;
		rec.is_priv        = opcode == 6'b101111 || opcode == 6'b010000;  // cache, cop0
		rec.is_controlflow = is_branch | is_jump_i | is_jump_r;
		rec.cf             = cf;
		rec.default_jump_i = jump_i;
		rec.default_jump_j = jump_j;

		casez (opcode)
			6'b000000: begin  // special
				rec.rs1 = rs;
				rec.rs2 = rt;
				rec.rd  = rd;
				case (funct)
					6'b000000, 6'b000010, 6'b000011,
					6'b000100, 6'b000110, 6'b000111,
					6'b100001, 6'b100011,
					6'b100100, 6'b100101, 6'b100110, 6'b100111,
					6'b101010, 6'b101011:
						rec.delayed_exec = 1'b1;  // simple single-cycle alu ops
					default:
						rec.delayed_exec = 1'b0;
				endcase
				case (funct)
					6'b000000: rec.op = cpu_pkg::OP_SLL;
					6'b000010: rec.op = cpu_pkg::OP_SRL;
					6'b000011: rec.op = cpu_pkg::OP_SRA;
					6'b000100: rec.op = cpu_pkg::OP_SLLV;
					6'b000110: rec.op = cpu_pkg::OP_SRLV;
					6'b000111: rec.op = cpu_pkg::OP_SRAV;
					6'b001000: rec.op = cpu_pkg::OP_JALR;  // jr
					6'b001001: rec.op = cpu_pkg::OP_JALR;
					6'b001010: rec.op = cpu_pkg::OP_MOVZ;
					6'b001011: rec.op = cpu_pkg::OP_MOVN;
					6'b001100: rec.op = cpu_pkg::OP_SYSCALL;
					6'b001101: rec.op = cpu_pkg::OP_BREAK;
					6'b001111: rec.op = cpu_pkg::OP_SLL;  // sync as nop
					6'b010000: rec.op = cpu_pkg::OP_MFHI;
					6'b010001: rec.op = cpu_pkg::OP_MTHI;
					6'b010010: rec.op = cpu_pkg::OP_MFLO;
					6'b010011: rec.op = cpu_pkg::OP_MTLO;
					6'b011000: rec.op = cpu_pkg::OP_MULT;
					6'b011001: rec.op = cpu_pkg::OP_MULTU;
					6'b011010: rec.op = cpu_pkg::OP_DIV;
					6'b011011: rec.op = cpu_pkg::OP_DIVU;
					6'b100000: rec.op = cpu_pkg::OP_ADD;
					6'b100001: rec.op = cpu_pkg::OP_ADDU;
					6'b100010: rec.op = cpu_pkg::OP_SUB;
					6'b100011: rec.op = cpu_pkg::OP_SUBU;
					6'b100100: rec.op = cpu_pkg::OP_AND;
					6'b100101: rec.op = cpu_pkg::OP_OR;
					6'b100110: rec.op = cpu_pkg::OP_XOR;
					6'b100111: rec.op = cpu_pkg::OP_NOR;
					6'b101010: rec.op = cpu_pkg::OP_SLT;
					6'b101011: rec.op = cpu_pkg::OP_SLTU;
					6'b110000: rec.op = cpu_pkg::OP_TGE;
					6'b110001: rec.op = cpu_pkg::OP_TGEU;
					6'b110010: rec.op = cpu_pkg::OP_TLT;
					6'b110011: rec.op = cpu_pkg::OP_TLTU;
					6'b110100: rec.op = cpu_pkg::OP_TEQ;
					6'b110110: rec.op = cpu_pkg::OP_TNE;
					default:   rec.op = cpu_pkg::OP_INVALID;
				endcase
			end
			6'b011100: begin  // special2
				rec.rs1 = rs;
				rec.rs2 = rt;
				rec.rd  = rd;
				case (funct)
					6'b000000: rec.op = cpu_pkg::OP_MADD;
					6'b000001: rec.op = cpu_pkg::OP_MADDU;
					6'b000010: rec.op = cpu_pkg::OP_MUL;
					6'b000100: rec.op = cpu_pkg::OP_MSUB;
					6'b000101: rec.op = cpu_pkg::OP_MSUBU;
					6'b100000: rec.op = cpu_pkg::OP_CLZ;
					6'b100001: rec.op = cpu_pkg::OP_CLO;
					default:   rec.op = cpu_pkg::OP_INVALID;
				endcase
			end
			6'b000001: begin  // regimm
				rec.rs1          = rs;
				rec.rd           = (rt[4:1] == 4'b1000) ? 5'd31 : 5'd0;  // link variants
				rec.use_imm      = 1'b1;
				rec.delayed_exec = (rt[3:1] == 3'b000) & delayed_branch;
				case (rt)
					5'b00000: rec.op = cpu_pkg::OP_BLTZ;
					5'b00001: rec.op = cpu_pkg::OP_BGEZ;
					5'b10000: rec.op = cpu_pkg::OP_BLTZAL;
					5'b10001: rec.op = cpu_pkg::OP_BGEZAL;
					5'b01000: rec.op = cpu_pkg::OP_TGE;
					5'b01001: rec.op = cpu_pkg::OP_TGEU;
					5'b01010: rec.op = cpu_pkg::OP_TLT;
					5'b01011: rec.op = cpu_pkg::OP_TLTU;
					5'b01100: rec.op = cpu_pkg::OP_TEQ;
					5'b01110: rec.op = cpu_pkg::OP_TNE;
					default:  rec.op = cpu_pkg::OP_INVALID;
				endcase
			end
			6'b0001??: begin  // beq, bne, blez, bgtz
				rec.rs1          = rs;
				rec.rs2          = rt;
				rec.delayed_exec = delayed_branch;
				case (opcode[1:0])
					2'b00: rec.op = cpu_pkg::OP_BEQ;
					2'b01: rec.op = cpu_pkg::OP_BNE;
					2'b10: rec.op = cpu_pkg::OP_BLEZ;
					2'b11: rec.op = cpu_pkg::OP_BGTZ;
				endcase
			end
			6'b001???: begin  // alu with immediate
				rec.rs1          = rs;
				rec.rd           = rt;
				rec.use_imm      = 1'b1;
				rec.delayed_exec = opcode[2:0] != 3'b000;  // addi may trap
				rec.imm_signed   = ~opcode[2];  // logic ops zero-extend
				case (opcode[2:0])
					3'b000: rec.op = cpu_pkg::OP_ADD;
					3'b001: rec.op = cpu_pkg::OP_ADDU;
					3'b010: rec.op = cpu_pkg::OP_SLT;
					3'b011: rec.op = cpu_pkg::OP_SLTU;
					3'b100: rec.op = cpu_pkg::OP_AND;
					3'b101: rec.op = cpu_pkg::OP_OR;
					3'b110: rec.op = cpu_pkg::OP_XOR;
					3'b111: rec.op = cpu_pkg::OP_LUI;
				endcase
			end
			6'b100???: begin  // loads
				rec.rs1     = rs;
				rec.rs2     = (opcode[1:0] == 2'b10) ? rt : 5'd0;  // lwl/lwr merge into rt
				rec.rd      = rt;
				rec.is_load = 1'b1;
				case (opcode[2:0])
					3'b000: rec.op = cpu_pkg::OP_LB;
					3'b001: rec.op = cpu_pkg::OP_LH;
					3'b010: rec.op = cpu_pkg::OP_LWL;
					3'b011: rec.op = cpu_pkg::OP_LW;
					3'b100: rec.op = cpu_pkg::OP_LBU;
					3'b101: rec.op = cpu_pkg::OP_LHU;
					3'b110: rec.op = cpu_pkg::OP_LWR;
					3'b111: rec.op = cpu_pkg::OP_INVALID;
				endcase
			end
			6'b101???: begin  // stores and cache
				rec.rs1      = rs;
				rec.rs2      = rt;
				rec.is_store = 1'b1;
				case (opcode[2:0])
					3'b000:  rec.op = cpu_pkg::OP_SB;
					3'b001:  rec.op = cpu_pkg::OP_SH;
					3'b010:  rec.op = cpu_pkg::OP_SWL;
					3'b011:  rec.op = cpu_pkg::OP_SW;
					3'b110:  rec.op = cpu_pkg::OP_SWR;
					3'b111:  rec.op = cpu_pkg::OP_CACHE;
					default: rec.op = cpu_pkg::OP_INVALID;
				endcase
			end
			6'b110000: begin  // ll
				rec.rs1     = rs;
				rec.rd      = rt;
				rec.op      = cpu_pkg::OP_LL;
				rec.is_load = 1'b1;
			end
			6'b111000: begin  // sc writes success flag back to rt
				rec.rs1      = rs;
				rec.rs2      = rt;
				rec.rd       = rt;
				rec.op       = cpu_pkg::OP_SC;
				rec.is_store = 1'b1;
			end
			6'b110011: rec.op = cpu_pkg::OP_SLL;  // pref
			6'b00001?: begin  // j, jal
				rec.rd = {5{opcode[0]}};
				rec.op = cpu_pkg::OP_JAL;
			end
			6'b010000: begin  // cop0
				case (rs)
					5'b00000: begin
						rec.op = cpu_pkg::OP_MFC0;
						rec.rd = rt;
					end
					5'b00100: begin
						rec.op  = cpu_pkg::OP_MTC0;
						rec.rs1 = rt;
					end
					5'b10000: begin
						rec.is_nonrw_priv = 1'b1;
						case (funct)
							6'b000001: rec.op = cpu_pkg::OP_TLBR;
							6'b000010: rec.op = cpu_pkg::OP_TLBWI;
							6'b000110: rec.op = cpu_pkg::OP_TLBWR;
							6'b001000: rec.op = cpu_pkg::OP_TLBP;
							6'b011000: rec.op = cpu_pkg::OP_ERET;
							6'b100000: rec.op = cpu_pkg::OP_SLL;  // wait
							default:   rec.op = cpu_pkg::OP_INVALID;
						endcase
					end
					default: rec.op = cpu_pkg::OP_INVALID;
				endcase
			end
			default: rec.op = cpu_pkg::OP_INVALID;
		endcase
	end

	assign dec.valid = in_valid;
	assign dec.rec   = rec;

endmodule

`default_nettype wire

//--- hdl/decode_queue.sv
`default_nettype none

module decode_queue #(
	parameter int queue_depth = 2
) (
	input  logic                    clk,
	input  logic                    rst_n,
	decode_if.sink                  push,
	output logic                    pop_valid,
	input  logic                    pop_ready,
	output cpu_pkg::decoded_instr_t pop_rec
);

	localparam int ptr_w = $clog2(queue_depth);
	localparam int cnt_w = $clog2(queue_depth + 1);

	cpu_pkg::decoded_instr_t mem [queue_depth];

	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w-1:0] wr_ptr;
	logic [cnt_w-1:0] count;
	logic             full;
	logic             push_fire;
	logic             pop_fire;

	function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] p);
		return (p == ptr_w'(queue_depth - 1)) ? '0 : p + 1'b1;
	endfunction

	assign full       = count == cnt_w'(queue_depth);
	assign pop_valid  = count != '0;
	assign pop_fire   = pop_valid && pop_ready;
	assign push.ready = !full || pop_fire;  // a full queue still takes one on a pop
	assign push_fire  = push.valid && push.ready;
	assign pop_rec    = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push_fire)
			mem[wr_ptr] <= push.rec;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_fire)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop_fire)
				rd_ptr <= next_ptr(rd_ptr);
			count <= count + cnt_w'(push_fire) - cnt_w'(pop_fire);
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		push.valid && full && !pop_ready |=> full && $stable(wr_ptr))
		else $error("write into full queue without a pop");

	a_head_stable: assert property (@(posedge clk) disable iff (!rst_n)
		pop_valid && !pop_ready |=> pop_valid && $stable(pop_rec))
		else $error("head record changed while stalled");

	a_count_range: assert property (@(posedge clk) disable iff (!rst_n)
		count <= cnt_w'(queue_depth))
		else $error("queue count above depth");

endmodule

`default_nettype wire

//--- hdl/decode_stage.sv
`default_nettype none

module decode_stage #(
	parameter bit delayed_branch = 1'b1,
	parameter int queue_depth    = 2
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 in_valid,
	output logic                 in_ready,
	input  cpu_pkg::virt_t       in_pc,
	input  logic [31:0]          in_instr,
	output logic                 out_valid,
	input  logic                 out_ready,
	output cpu_pkg::op_t         out_op,
	output cpu_pkg::reg_addr_t   out_rs1,
	output cpu_pkg::reg_addr_t   out_rs2,
	output cpu_pkg::reg_addr_t   out_rd,
	output logic                 out_use_imm,
	output logic                 out_imm_signed,
	output logic                 out_is_load,
	output logic                 out_is_store,
	output logic                 out_is_priv,
	output logic                 out_is_nonrw_priv,
	output logic                 out_delayed_exec,
	output logic                 out_is_controlflow,
	output cpu_pkg::cf_t         out_cf,
	output cpu_pkg::virt_t       out_jump_i,
	output cpu_pkg::virt_t       out_jump_j
);

	decode_if dec_bus ();

	cpu_pkg::decoded_instr_t head;

	decoder #(
		.delayed_branch (delayed_branch)
	) u_decoder (
		.pc       (in_pc),
		.instr    (in_instr),
		.in_valid (in_valid),
		.dec      (dec_bus.source)
	);

	decode_queue #(
		.queue_depth (queue_depth)
	) u_queue (
		.clk       (clk),
		.rst_n     (rst_n),
		.push      (dec_bus.sink),
		.pop_valid (out_valid),
		.pop_ready (out_ready),
		.pop_rec   (head)
	);

	assign in_ready = dec_bus.ready;

	assign out_op             = head.op;
	assign out_rs1            = head.rs1;
	assign out_rs2            = head.rs2;
	assign out_rd             = head.rd;
	assign out_use_imm        = head.use_imm;
	assign out_imm_signed     = head.imm_signed;
	assign out_is_load        = head.is_load;
	assign out_is_store       = head.is_store;
	assign out_is_priv        = head.is_priv;
	assign out_is_nonrw_priv  = head.is_nonrw_priv;
	assign out_delayed_exec   = head.delayed_exec;
	assign out_is_controlflow = head.is_controlflow;
	assign out_cf             = head.cf;
	assign out_jump_i         = head.default_jump_i;
	assign out_jump_j         = head.default_jump_j;

endmodule

`default_nettype wire

//--- tests/decode_model.svh
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// trap group of special funct 11xxxx and regimm rt 01xxx
function automatic cpu_pkg::op_t trap_op(input logic [2:0] k);
	case (k)
		3'd0: return cpu_pkg::OP_TGE;
		3'd1: return cpu_pkg::OP_TGEU;
		3'd2: return cpu_pkg::OP_TLT;
		3'd3: return cpu_pkg::OP_TLTU;
		3'd4: return cpu_pkg::OP_TEQ;
		3'd6: return cpu_pkg::OP_TNE;
		default: return cpu_pkg::OP_INVALID;
	endcase
endfunction

function automatic cpu_pkg::op_t special_op(input logic [5:0] fn);
	if (fn[5:3] == 3'b100)
		return cpu_pkg::op_t'(cpu_pkg::OP_ADD + fn[2:0]);  // add .. nor in funct order
	if (fn[5:3] == 3'b110)
		return trap_op(fn[2:0]);
	case (fn)
		6'h00: return cpu_pkg::OP_SLL;
		6'h02: return cpu_pkg::OP_SRL;
		6'h03: return cpu_pkg::OP_SRA;
		6'h04: return cpu_pkg::OP_SLLV;
		6'h06: return cpu_pkg::OP_SRLV;
		6'h07: return cpu_pkg::OP_SRAV;
		6'h08: return cpu_pkg::OP_JALR;
		6'h09: return cpu_pkg::OP_JALR;
		6'h0a: return cpu_pkg::OP_MOVZ;
		6'h0b: return cpu_pkg::OP_MOVN;
		6'h0c: return cpu_pkg::OP_SYSCALL;
		6'h0d: return cpu_pkg::OP_BREAK;
		6'h0f: return cpu_pkg::OP_SLL;  // sync
		6'h10: return cpu_pkg::OP_MFHI;
		6'h11: return cpu_pkg::OP_MTHI;
		6'h12: return cpu_pkg::OP_MFLO;
		6'h13: return cpu_pkg::OP_MTLO;
		6'h18: return cpu_pkg::OP_MULT;
		6'h19: return cpu_pkg::OP_MULTU;
		6'h1a: return cpu_pkg::OP_DIV;
		6'h1b: return cpu_pkg::OP_DIVU;
		6'h2a: return cpu_pkg::OP_SLT;
		6'h2b: return cpu_pkg::OP_SLTU;
		default: return cpu_pkg::OP_INVALID;
	endcase
endfunction

// shifts, addu/subu, logic and slt issue without a stall
function automatic bit simple_alu(input logic [5:0] fn);
	return (fn[5:3] == 3'b000 && fn != 6'h01 && fn != 6'h05)
		|| fn == 6'h21 || fn == 6'h23
		|| (fn >= 6'h24 && fn <= 6'h27)
		|| fn == 6'h2a || fn == 6'h2b;
endfunction

function automatic cpu_pkg::op_t special2_op(input logic [5:0] fn);
	case (fn)
		6'h00: return cpu_pkg::OP_MADD;
		6'h01: return cpu_pkg::OP_MADDU;
		6'h02: return cpu_pkg::OP_MUL;
		6'h04: return cpu_pkg::OP_MSUB;
		6'h05: return cpu_pkg::OP_MSUBU;
		6'h20: return cpu_pkg::OP_CLZ;
		6'h21: return cpu_pkg::OP_CLO;
		default: return cpu_pkg::OP_INVALID;
	endcase
endfunction

function automatic cpu_pkg::op_t imm_alu_op(input logic [2:0] k);
	case (k)
		3'd0: return cpu_pkg::OP_ADD;
		3'd1: return cpu_pkg::OP_ADDU;
		3'd2: return cpu_pkg::OP_SLT;
		3'd3: return cpu_pkg::OP_SLTU;
		3'd4: return cpu_pkg::OP_AND;
		3'd5: return cpu_pkg::OP_OR;
		3'd6: return cpu_pkg::OP_XOR;
		default: return cpu_pkg::OP_LUI;
	endcase
endfunction

function automatic cpu_pkg::op_t store_op(input logic [2:0] k);
	case (k)
		3'd0: return cpu_pkg::OP_SB;
		3'd1: return cpu_pkg::OP_SH;
		3'd2: return cpu_pkg::OP_SWL;
		3'd3: return cpu_pkg::OP_SW;
		3'd6: return cpu_pkg::OP_SWR;
		3'd7: return cpu_pkg::OP_CACHE;
		default: return cpu_pkg::OP_INVALID;
	endcase
endfunction

function automatic cpu_pkg::decoded_instr_t ref_decode(input cpu_pkg::virt_t pc,
		input logic [31:0] w, input bit delay_slot_branch);
	logic [5:0]              opc;
	logic [5:0]              fn;
	logic [4:0]              rs;
	logic [4:0]              rt;
	logic [4:0]              rd;
	logic                    regimm_br;
	logic                    branch;
	logic                    jump;
	cpu_pkg::virt_t          next_pc;
	cpu_pkg::decoded_instr_t r;

	opc       = w[31:26];
	rs        = w[25:21];
	rt        = w[20:16];
	rd        = w[15:11];
	fn        = w[5:0];
	next_pc   = pc + 32'd4;
	regimm_br = opc == 6'h01 && (rt == 5'd0 || rt == 5'd1 || rt == 5'd16 || rt == 5'd17);
	branch    = opc[5:2] == 4'b0001 || regimm_br;
	jump      = opc == 6'h02 || opc == 6'h03 || (opc == 6'h00 && (fn == 6'h08 || fn == 6'h09));

	r                = '0;
	r.op             = cpu_pkg::OP_SLL;
	r.imm_signed     = 1'b1;
	r.is_priv        = opc == 6'h10 || opc == 6'h2f;
	r.is_controlflow = branch || jump;
	r.default_jump_i = next_pc + ({{16{w[15]}}, w[15:0]} << 2);
	r.default_jump_j = {next_pc[31:28], w[25:0], 2'b00};

	if (branch)
		r.cf = cpu_pkg::CF_BRANCH;
	else if (opc == 6'h00 && fn == 6'h08 && rs == 5'd31)
		r.cf = cpu_pkg::CF_RETURN;
	else if (opc == 6'h03 || (opc == 6'h00 && fn == 6'h09 && rd == 5'd31))
		r.cf = cpu_pkg::CF_CALL;
	else if (jump)
		r.cf = cpu_pkg::CF_JUMP;
	else
		r.cf = cpu_pkg::CF_NONE;

	if (opc == 6'h00 || opc == 6'h1c) begin
		r.rs1 = rs;
		r.rs2 = rt;
		r.rd  = rd;
		if (opc == 6'h00) begin
			r.op           = special_op(fn);
			r.delayed_exec = simple_alu(fn);
		end else begin
			r.op = special2_op(fn);
		end
	end else if (opc == 6'h01) begin
		r.rs1          = rs;
		r.rd           = (rt == 5'd16 || rt == 5'd17) ? 5'd31 : 5'd0;
		r.use_imm      = 1'b1;
		r.delayed_exec = regimm_br && delay_slot_branch;
		if (rt[4:3] == 2'b01)
			r.op = trap_op(rt[2:0]);
		else if (rt == 5'd0)
			r.op = cpu_pkg::OP_BLTZ;
		else if (rt == 5'd1)
			r.op = cpu_pkg::OP_BGEZ;
		else if (rt == 5'd16)
			r.op = cpu_pkg::OP_BLTZAL;
		else if (rt == 5'd17)
			r.op = cpu_pkg::OP_BGEZAL;
		else
			r.op = cpu_pkg::OP_INVALID;
	end else if (opc[5:2] == 4'b0001) begin
		r.rs1          = rs;
		r.rs2          = rt;
		r.delayed_exec = delay_slot_branch;
		r.op           = cpu_pkg::op_t'(cpu_pkg::OP_BEQ + opc[1:0]);
	end else if (opc[5:3] == 3'b001) begin
		r.rs1          = rs;
		r.rd           = rt;
		r.use_imm      = 1'b1;
		r.imm_signed   = opc < 6'h0c;
		r.delayed_exec = opc != 6'h08;
		r.op           = imm_alu_op(opc[2:0]);
	end else if (opc[5:3] == 3'b100) begin
		r.rs1     = rs;
		r.rs2     = (opc == 6'h22 || opc == 6'h26) ? rt : 5'd0;  // lwl, lwr
		r.rd      = rt;
		r.is_load = 1'b1;
		if (opc == 6'h27)
			r.op = cpu_pkg::OP_INVALID;
		else
			r.op = cpu_pkg::op_t'(cpu_pkg::OP_LB + opc[2:0]);
	end else if (opc[5:3] == 3'b101) begin
		r.rs1      = rs;
		r.rs2      = rt;
		r.is_store = 1'b1;
		r.op       = store_op(opc[2:0]);
	end else if (opc == 6'h30) begin
		r.rs1     = rs;
		r.rd      = rt;
		r.is_load = 1'b1;
		r.op      = cpu_pkg::OP_LL;
	end else if (opc == 6'h38) begin
		r.rs1      = rs;
		r.rs2      = rt;
		r.rd       = rt;
		r.is_store = 1'b1;
		r.op       = cpu_pkg::OP_SC;
	end else if (opc == 6'h02 || opc == 6'h03) begin
		r.rd = (opc == 6'h03) ? 5'd31 : 5'd0;
		r.op = cpu_pkg::OP_JAL;
	end else if (opc == 6'h10) begin
		if (rs == 5'd0) begin
			r.op = cpu_pkg::OP_MFC0;
			r.rd = rt;
		end else if (rs == 5'd4) begin
			r.op  = cpu_pkg::OP_MTC0;
			r.rs1 = rt;
		end else if (rs == 5'd16) begin
			r.is_nonrw_priv = 1'b1;
			case (fn)
				6'h01: r.op = cpu_pkg::OP_TLBR;
				6'h02: r.op = cpu_pkg::OP_TLBWI;
				6'h06: r.op = cpu_pkg::OP_TLBWR;
				6'h08: r.op = cpu_pkg::OP_TLBP;
				6'h18: r.op = cpu_pkg::OP_ERET;
				6'h20: r.op = cpu_pkg::OP_SLL;  // wait
				default: r.op = cpu_pkg::OP_INVALID;
			endcase
		end else begin
			r.op = cpu_pkg::OP_INVALID;
		end
	end else if (opc != 6'h33) begin  // pref stays a nop
		r.op = cpu_pkg::OP_INVALID;
	end
	return r;
endfunction

`endif

//--- tests/tb_decode_stage.sv
`default_nettype none

module tb_decode_stage;

	localparam bit delay_br   = 1'b1;
	localparam int depth      = 2;
	localparam int wait_limit = 200;

	logic                 clk;
	logic                 rst_n;
	logic                 in_valid;
	logic                 in_ready;
	cpu_pkg::virt_t       in_pc;
	logic [31:0]          in_instr;
	logic                 out_valid;
	logic                 out_ready;
	cpu_pkg::op_t         out_op;
	cpu_pkg::reg_addr_t   out_rs1;
	cpu_pkg::reg_addr_t   out_rs2;
	cpu_pkg::reg_addr_t   out_rd;
	logic                 out_use_imm;
	logic                 out_imm_signed;
	logic                 out_is_load;
	logic                 out_is_store;
	logic                 out_is_priv;
	logic                 out_is_nonrw_priv;
	logic                 out_delayed_exec;
	logic                 out_is_controlflow;
	cpu_pkg::cf_t         out_cf;
	cpu_pkg::virt_t       out_jump_i;
	cpu_pkg::virt_t       out_jump_j;

	int          errors;
	int          timeouts;
	int          ready_mode;  // 0 always ready, 1 random, 2 held low
	logic [31:0] stim_seed;
	logic [31:0] rdy_seed;

	cpu_pkg::decoded_instr_t exp_q [$];

	logic [31:0] directed [56] = '{
		32'h00221821, 32'h00221822, 32'h000520c0, 32'h00c74007,
		32'h00220018, 32'h0022001b, 32'h00004810, 32'h0000000c,
		32'h70221802, 32'h70220000, 32'h70221820, 32'h2022fffc,
		32'h2422ffff, 32'h2822ffff, 32'h3022ffff, 32'h34228001,
		32'h3c051234, 32'h80220010, 32'h84220010, 32'h88220010,
		32'h8c22fff0, 32'h90220010, 32'h94220010, 32'h98220010,
		32'ha0220010, 32'ha4220010, 32'ha8220010, 32'hac22fff0,
		32'hb8220010, 32'hbc220010, 32'hc0220000, 32'he0220000,
		32'h10220005, 32'h1422fffb, 32'h18200003, 32'h1c20ffff,
		32'h04200004, 32'h04310010, 32'h0430fffe, 32'h042c0007,
		32'h08100000, 32'h0c000040, 32'h03e00008, 32'h00a00008,
		32'h0080f809, 32'h40026000, 32'h40826000, 32'h42000018,
		32'h42000002, 32'h42000008, 32'hfc000000, 32'h0000003f,
		32'h04050000, 32'hb0220010, 32'h7000003f, 32'h42000020
	};

	`include "decode_model.svh"

	decode_stage #(
		.delayed_branch (delay_br),
		.queue_depth    (depth)
	) dut (
		.clk                (clk),
		.rst_n              (rst_n),
		.in_valid           (in_valid),
		.in_ready           (in_ready),
		.in_pc              (in_pc),
		.in_instr           (in_instr),
		.out_valid          (out_valid),
		.out_ready          (out_ready),
		.out_op             (out_op),
		.out_rs1            (out_rs1),
		.out_rs2            (out_rs2),
		.out_rd             (out_rd),
		.out_use_imm        (out_use_imm),
		.out_imm_signed     (out_imm_signed),
		.out_is_load        (out_is_load),
		.out_is_store       (out_is_store),
		.out_is_priv        (out_is_priv),
		.out_is_nonrw_priv  (out_is_nonrw_priv),
		.out_delayed_exec   (out_delayed_exec),
		.out_is_controlflow (out_is_controlflow),
		.out_cf             (out_cf),
		.out_jump_i         (out_jump_i),
		.out_jump_j         (out_jump_j)
	);

	always #2 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic cpu_pkg::decoded_instr_t capture_outputs();
		cpu_pkg::decoded_instr_t r;
		r.rs1            = out_rs1;
		r.rs2            = out_rs2;
		r.rd             = out_rd;
		r.op             = out_op;
		r.use_imm        = out_use_imm;
		r.imm_signed     = out_imm_signed;
		r.is_load        = out_is_load;
		r.is_store       = out_is_store;
		r.is_priv        = out_is_priv;
		r.is_nonrw_priv  = out_is_nonrw_priv;
		r.delayed_exec   = out_delayed_exec;
		r.is_controlflow = out_is_controlflow;
		r.cf             = out_cf;
		r.default_jump_i = out_jump_i;
		r.default_jump_j = out_jump_j;
		return r;
	endfunction

	task automatic check_field(input string name, input logic [31:0] exp,
			input logic [31:0] act);
		assert (act === exp) else begin
			errors++;
			$display("ERR %s expected %h got %h", name, exp, act);
		end
	endtask

	task automatic compare_rec(input cpu_pkg::decoded_instr_t e,
			input cpu_pkg::decoded_instr_t g);
		check_field("out_op", e.op, g.op);
		check_field("out_rs1", e.rs1, g.rs1);
		check_field("out_rs2", e.rs2, g.rs2);
		check_field("out_rd", e.rd, g.rd);
		check_field("out_use_imm", e.use_imm, g.use_imm);
		check_field("out_imm_signed", e.imm_signed, g.imm_signed);
		check_field("out_is_load", e.is_load, g.is_load);
		check_field("out_is_store", e.is_store, g.is_store);
		check_field("out_is_priv", e.is_priv, g.is_priv);
		check_field("out_is_nonrw_priv", e.is_nonrw_priv, g.is_nonrw_priv);
		check_field("out_delayed_exec", e.delayed_exec, g.delayed_exec);
		check_field("out_is_controlflow", e.is_controlflow, g.is_controlflow);
		check_field("out_cf", e.cf, g.cf);
		check_field("out_jump_i", e.default_jump_i, g.default_jump_i);
		check_field("out_jump_j", e.default_jump_j, g.default_jump_j);
	endtask

	// called just after a rising edge, returns just after a rising edge
	task automatic send(input cpu_pkg::virt_t pc, input logic [31:0] word);
		int waited;
		waited   = 0;
		in_valid = 1'b1;
		in_pc    = pc;
		in_instr = word;
		@(negedge clk);
		while (!in_ready && waited < wait_limit) begin
			@(negedge clk);
			waited++;
		end
		if (in_ready)
			exp_q.push_back(ref_decode(pc, word, delay_br));  // taken on next edge
		else begin
			timeouts++;
			$display("timeout: in_ready stayed low for pc %h", pc);
		end
		@(posedge clk);
		#1;
		in_valid = 1'b0;
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		@(negedge clk);
		while ((exp_q.size() != 0 || out_valid) && waited < wait_limit) begin
			@(negedge clk);
			waited++;
		end
		if (exp_q.size() != 0 || out_valid) begin
			timeouts++;
			$display("timeout: out_valid never drained the queue");
		end
	endtask

	initial begin : ready_drive
		forever begin
			@(posedge clk);
			#1;
			if (ready_mode == 0)
				out_ready = 1'b1;
			else if (ready_mode == 1) begin
				rdy_seed  = lcg_next(rdy_seed);
				out_ready = rdy_seed[31:30] != 2'b00;
			end else
				out_ready = 1'b0;
		end
	end

	initial begin : compare_outputs
		cpu_pkg::decoded_instr_t got;
		cpu_pkg::decoded_instr_t held;
		bit                      stalled;
		stalled = 0;
		forever begin
			@(negedge clk);
			if (rst_n) begin
				assert (!stalled || out_valid) else begin
					errors++;
					$display("out_valid dropped while out_ready was low");
				end
				if (out_valid) begin
					got = capture_outputs();
					assert (!stalled || got === held) else begin
						errors++;
						$display("output record changed while out_ready was low");
					end
					if (out_ready) begin
						assert (exp_q.size() != 0) else begin
							errors++;
							$display("output record with no accepted instruction");
						end
						if (exp_q.size() != 0)
							compare_rec(exp_q.pop_front(), got);
					end
					stalled = !out_ready;
					held    = got;
				end else
					stalled = 0;
			end
		end
	end

	initial begin
		cpu_pkg::virt_t pc;
		logic [31:0]    word;
		clk        = 1'b0;
		rst_n      = 1'b0;
		in_valid   = 1'b0;
		in_pc      = '0;
		in_instr   = '0;
		out_ready  = 1'b0;
		errors     = 0;
		timeouts   = 0;
		ready_mode = 2;
		stim_seed  = 32'h712d;
		rdy_seed   = 32'h712d ^ 32'h5a5a0000;  // separate stream for out_ready

		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(negedge clk);
		check_field("out_valid", 32'd0, out_valid);
		check_field("in_ready", 32'd1, in_ready);

		// one of each instruction class
		ready_mode = 0;
		@(posedge clk);
		#1;
		foreach (directed[i])
			send(32'h0040_0000 + 32'(i) * 4, directed[i]);
		drain();

		// branch and jump targets with half the pcs near a 256 MB boundary
		@(posedge clk);
		#1;
		for (int i = 0; i < 64; i++) begin
			stim_seed = lcg_next(stim_seed);
			if (i[0])
				pc = {stim_seed[31:2], 2'b00};
			else
				pc = {stim_seed[31:28], 28'hffffff0} + {stim_seed[3:2], 2'b00};
			stim_seed = lcg_next(stim_seed);
			if (i[1])
				word = {6'b000100, stim_seed[25:0]};  // beq
			else
				word = {5'b00001, i[2], stim_seed[25:0]};  // j or jal
			send(pc, word);
		end
		drain();

		// fill the queue with the output blocked
		ready_mode = 2;
		@(posedge clk);
		#1;
		for (int i = 0; i < depth; i++)
			send(32'h0080_0000 + 32'(i) * 4, directed[i]);
		in_valid = 1'b1;
		in_pc    = 32'h0080_0100;
		in_instr = 32'h00221821;
		repeat (4) begin
			@(negedge clk);
			check_field("in_ready", 32'd0, in_ready);
			check_field("out_valid", 32'd1, out_valid);
		end
		@(posedge clk);
		#1;
		in_valid = 1'b0;
		@(negedge clk);
		ready_mode = 0;
		drain();

		// random stream against random back-pressure
		ready_mode = 1;
		@(posedge clk);
		#1;
		for (int i = 0; i < 2000; i++) begin
			stim_seed = lcg_next(stim_seed);
			pc        = {stim_seed[31:2], 2'b00};
			stim_seed = lcg_next(stim_seed);
			word      = stim_seed;
			send(pc, word);
			if (stim_seed[7]) begin  // idle gap
				@(posedge clk);
				#1;
			end
		end
		drain();

		$display("errors %0d, timeouts %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- decode_stage.f
+incdir+tests
common/cpu_pkg.sv
common/decode_if.sv
decoder/decode_branch.sv
decoder/decoder.sv
hdl/decode_queue.sv
hdl/decode_stage.sv
tests/tb_decode_stage.sv
